/* csr_pkg.sv */
package csr_pkg;

  typedef logic [31:0] word_t;
  typedef logic [13:0] csr_addr_t;
  typedef logic [5:0]  ecode_t;
  typedef logic [8:0]  esubcode_t;
  typedef logic [7:0]  excp_vec_t;
  typedef logic [1:0]  rdcnt_t;

  // csr addresses
  localparam csr_addr_t CSR_CRMD   = 14'h0;
  localparam csr_addr_t CSR_PRMD   = 14'h1;
  localparam csr_addr_t CSR_ECTL   = 14'h4;
  localparam csr_addr_t CSR_ESTAT  = 14'h5;
  localparam csr_addr_t CSR_ERA    = 14'h6;
  localparam csr_addr_t CSR_BADV   = 14'h7;
  localparam csr_addr_t CSR_EENTRY = 14'hc;
  localparam csr_addr_t CSR_SAVE0  = 14'h30;
  localparam csr_addr_t CSR_SAVE1  = 14'h31;
  localparam csr_addr_t CSR_SAVE2  = 14'h32;
  localparam csr_addr_t CSR_SAVE3  = 14'h33;
  localparam csr_addr_t CSR_TID    = 14'h40;
  localparam csr_addr_t CSR_TCFG   = 14'h41;
  localparam csr_addr_t CSR_TVAL   = 14'h42;
  localparam csr_addr_t CSR_TICLR  = 14'h44;

  localparam int NUM_SAVE = 4;
  localparam csr_addr_t CSR_SAVE_ADDR [NUM_SAVE] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3};

  // writable bits per register
  localparam word_t WMASK_CRMD   = 32'h0000_01ff;
  localparam word_t WMASK_PRMD   = 32'h0000_0007;
  localparam word_t WMASK_ECTL   = 32'h0000_1bff;
  localparam word_t WMASK_ESTAT  = 32'h0000_0003;
  localparam word_t WMASK_EENTRY = 32'hffff_ffc0;
  localparam word_t WMASK_FULL   = 32'hffff_ffff;

  // field positions
  localparam int CRMD_PLV_HI      = 1;
  localparam int CRMD_IE          = 2;
  localparam int CRMD_DA          = 3;
  localparam int PRMD_PPLV_HI     = 1;
  localparam int PRMD_PIE         = 2;
  localparam int ESTAT_SWI_HI     = 1;
  localparam int ESTAT_HWI_LO     = 2;
  localparam int ESTAT_HWI_HI     = 9;
  localparam int ESTAT_TI         = 11;
  localparam int ESTAT_IS_HI      = 12;
  localparam int ESTAT_ECODE_LO   = 16;
  localparam int ESTAT_ECODE_HI   = 21;
  localparam int ESTAT_ESUB_LO    = 22;
  localparam int ESTAT_ESUB_HI    = 30;
  localparam int TCFG_EN          = 0;
  localparam int TCFG_PERIODIC    = 1;
  localparam int TCFG_INITVAL_LO  = 2;
  localparam int TICLR_CLR        = 0;

  // cause bits in excp_vec_t, lowest index has highest priority
  localparam int EXC_INT  = 0;
  localparam int EXC_ADEF = 1;
  localparam int EXC_ADEM = 2;
  localparam int EXC_ALE  = 3;
  localparam int EXC_SYS  = 4;
  localparam int EXC_BRK  = 5;
  localparam int EXC_INE  = 6;
  localparam int EXC_IPE  = 7;

  localparam ecode_t ECODE_INT = 6'h0;
  localparam ecode_t ECODE_ADE = 6'h8;
  localparam ecode_t ECODE_ALE = 6'h9;
  localparam ecode_t ECODE_SYS = 6'hb;
  localparam ecode_t ECODE_BRK = 6'hc;
  localparam ecode_t ECODE_INE = 6'hd;
  localparam ecode_t ECODE_IPE = 6'he;
  localparam esubcode_t ESUBCODE_ADEM = 9'd1;

  localparam rdcnt_t RDCNT_NONE = 2'd0;
  localparam rdcnt_t RDCNT_ID   = 2'd1;
  localparam rdcnt_t RDCNT_LOW  = 2'd2;
  localparam rdcnt_t RDCNT_HIGH = 2'd3;

  // direct address mode out of reset
  localparam word_t CRMD_RESET = word_t'(1) << CRMD_DA;

  function automatic word_t wmask_merge(word_t old_val, word_t new_val, word_t mask);
    return (old_val & ~mask) | (new_val & mask);
  endfunction

endpackage

/* csr_excp_unit.sv */
`timescale 1ns/1ps

module csr_excp_unit import csr_pkg::*; (
  input  excp_vec_t excp_i,
  input  word_t     pc_i,
  input  word_t     vaddr_i,
  output logic      excp_valid_o,
  output ecode_t    ecode_o,
  output esubcode_t esubcode_o,
  output logic      badv_we_o,
  output word_t     badv_val_o
);

  logic [2:0] win;
  logic       addr_err;

  // pick the lowest set index
  always_comb begin
    win = '0;
    for (int i = $bits(excp_vec_t) - 1; i >= 0; i--) begin
      if (excp_i[i]) begin
        win = 3'(i);
      end
    end
  end

  always_comb begin
    ecode_o    = ECODE_INT;
    esubcode_o = '0;
    case (win)
      EXC_INT: begin
        ecode_o = ECODE_INT;
      end
      EXC_ADEF: begin
        ecode_o = ECODE_ADE;
      end
      EXC_ADEM: begin
        ecode_o    = ECODE_ADE;
        esubcode_o = ESUBCODE_ADEM;
      end
      EXC_ALE: begin
        ecode_o = ECODE_ALE;
      end
      EXC_SYS: begin
        ecode_o = ECODE_SYS;
      end
      EXC_BRK: begin
        ecode_o = ECODE_BRK;
      end
      EXC_INE: begin
        ecode_o = ECODE_INE;
      end
      EXC_IPE: begin
        ecode_o = ECODE_IPE;
      end
      default: begin
        ecode_o = ECODE_INT;
      end
    endcase
  end

  assign excp_valid_o = |excp_i;

  // address faults capture a bad va
  assign addr_err = (win == EXC_ADEF) || (win == EXC_ADEM) || (win == EXC_ALE);
  assign badv_we_o = excp_valid_o && addr_err;
  // fetch fault reports the pc itself
  assign badv_val_o = (win == EXC_ADEF) ? pc_i : vaddr_i;

endmodule

/* csr_timer.sv */
`timescale 1ns/1ps

module csr_timer import csr_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        csr_we_i,
  input  csr_addr_t   csr_w_addr_i,
  input  word_t       csr_w_mask_i,
  input  word_t       csr_w_data_i,
  output word_t       tcfg_o,
  output word_t       tval_o,
  output logic        timer_int_o,
  output logic [63:0] stable_cnt_o
);

  word_t       tcfg_q;
  word_t       tval_q;
  word_t       tcfg_next;
  word_t       reload_val;
  logic        timer_en_q;
  logic        ti_q;
  logic        tcfg_we;
  logic        ticlr_we;
  logic        ti_clr;
  logic        expire;
  logic [63:0] stable_cnt_q;

  // initval field scaled by 4, low bits cleared
  function automatic word_t initval_ticks(word_t cfg);
    return (cfg >> TCFG_INITVAL_LO) << TCFG_INITVAL_LO;
  endfunction

  assign tcfg_we   = csr_we_i && (csr_w_addr_i == CSR_TCFG);
  assign ticlr_we  = csr_we_i && (csr_w_addr_i == CSR_TICLR);
  assign ti_clr    = ticlr_we && csr_w_mask_i[TICLR_CLR] && csr_w_data_i[TICLR_CLR];
  assign tcfg_next = wmask_merge(tcfg_q, csr_w_data_i, csr_w_mask_i & WMASK_FULL);
  assign expire    = timer_en_q && (tval_q == '0);

  // one-shot parks at all ones
  assign reload_val = tcfg_q[TCFG_PERIODIC] ? initval_ticks(tcfg_q) : '1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_q     <= '0;
      tval_q     <= '0;
      timer_en_q <= 1'b0;
    end else begin
      if (tcfg_we) begin
        tcfg_q     <= tcfg_next;
        tval_q     <= initval_ticks(tcfg_next);
        timer_en_q <= tcfg_next[TCFG_EN];
      end else if (expire) begin
        tval_q     <= reload_val;
        timer_en_q <= tcfg_q[TCFG_PERIODIC];
      end else if (timer_en_q) begin
        tval_q <= tval_q - 32'd1;
      end
    end
  end

  // clear beats a same-cycle expiry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ti_q <= 1'b0;
    end else if (ti_clr) begin
      ti_q <= 1'b0;
    end else if (expire) begin
      ti_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stable_cnt_q <= '0;
    end else begin
      stable_cnt_q <= stable_cnt_q + 64'd1;
    end
  end

  assign tcfg_o       = tcfg_q;
  assign tval_o       = tval_q;
  assign timer_int_o  = ti_q;
  assign stable_cnt_o = stable_cnt_q;

  // a stopped timer holds its count until reconfigured
  a_tval_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!timer_en_q && !tcfg_we) |=> $stable(tval_q));

endmodule

/* csr_regfile.sv */
`timescale 1ns/1ps

module csr_regfile import csr_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        csr_we_i,
  input  csr_addr_t   csr_w_addr_i,
  input  word_t       csr_w_mask_i,
  input  word_t       csr_w_data_i,
  input  csr_addr_t   csr_r_addr_i,
  input  rdcnt_t      rdcnt_i,
  input  logic        excp_valid_i,
  input  ecode_t      ecode_i,
  input  esubcode_t   esubcode_i,
  input  logic        badv_we_i,
  input  word_t       badv_val_i,
  input  word_t       pc_i,
  input  logic        ertn_i,
  input  logic [7:0]  int_i,
  input  word_t       tcfg_i,
  input  word_t       tval_i,
  input  logic        timer_int_i,
  input  logic [63:0] stable_cnt_i,
  output word_t       crmd_o,
  output word_t       era_o,
  output word_t       eentry_o,
  output logic        int_o,
  output word_t       csr_r_data_o
);

  word_t crmd_q;
  word_t prmd_q;
  word_t ectl_q;
  word_t estat_q;
  word_t era_q;
  word_t badv_q;
  word_t eentry_q;
  word_t tid_q;
  word_t save_q [NUM_SAVE];
  word_t estat_word;
  word_t estat_wr;
  word_t rd_data;

  logic wr_crmd;
  logic wr_prmd;
  logic wr_ectl;
  logic wr_estat;
  logic wr_era;
  logic wr_badv;
  logic wr_eentry;
  logic wr_tid;

  function automatic word_t wr_val(word_t old_val, word_t wmask);
    return wmask_merge(old_val, csr_w_data_i, csr_w_mask_i & wmask);
  endfunction

  assign wr_crmd   = csr_we_i && (csr_w_addr_i == CSR_CRMD);
  assign wr_prmd   = csr_we_i && (csr_w_addr_i == CSR_PRMD);
  assign wr_ectl   = csr_we_i && (csr_w_addr_i == CSR_ECTL);
  assign wr_estat  = csr_we_i && (csr_w_addr_i == CSR_ESTAT);
  assign wr_era    = csr_we_i && (csr_w_addr_i == CSR_ERA);
  assign wr_badv   = csr_we_i && (csr_w_addr_i == CSR_BADV);
  assign wr_eentry = csr_we_i && (csr_w_addr_i == CSR_EENTRY);
  assign wr_tid    = csr_we_i && (csr_w_addr_i == CSR_TID);
  assign estat_wr  = wr_val(estat_q, WMASK_ESTAT);

  // csr writes are last so they win over events
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q <= CRMD_RESET;
      prmd_q <= '0;
    end else begin
      if (excp_valid_i) begin
        prmd_q[PRMD_PPLV_HI:0] <= crmd_q[CRMD_PLV_HI:0];
        prmd_q[PRMD_PIE]       <= crmd_q[CRMD_IE];
        crmd_q[CRMD_PLV_HI:0]  <= '0;
        crmd_q[CRMD_IE]        <= 1'b0;
      end
      if (ertn_i) begin
        crmd_q[CRMD_PLV_HI:0] <= prmd_q[PRMD_PPLV_HI:0];
        crmd_q[CRMD_IE]       <= prmd_q[PRMD_PIE];
      end
      if (wr_crmd) begin
        crmd_q <= wr_val(crmd_q, WMASK_CRMD);
      end
      if (wr_prmd) begin
        prmd_q <= wr_val(prmd_q, WMASK_PRMD);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      estat_q <= '0;
      era_q   <= '0;
      badv_q  <= '0;
    end else begin
      // hw lines land one cycle late
      estat_q[ESTAT_HWI_HI:ESTAT_HWI_LO] <= int_i;
      if (excp_valid_i) begin
        estat_q[ESTAT_ECODE_HI:ESTAT_ECODE_LO] <= ecode_i;
        estat_q[ESTAT_ESUB_HI:ESTAT_ESUB_LO]   <= esubcode_i;
        era_q <= pc_i;
      end
      if (badv_we_i) begin
        badv_q <= badv_val_i;
      end
      // only the swi bits are writable
      if (wr_estat) begin
        estat_q[ESTAT_SWI_HI:0] <= estat_wr[ESTAT_SWI_HI:0];
      end
      if (wr_era) begin
        era_q <= wr_val(era_q, WMASK_FULL);
      end
      if (wr_badv) begin
        badv_q <= wr_val(badv_q, WMASK_FULL);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ectl_q   <= '0;
      eentry_q <= '0;
      tid_q    <= '0;
      for (int i = 0; i < NUM_SAVE; i++) begin
        save_q[i] <= '0;
      end
    end else begin
      if (wr_ectl) begin
        ectl_q <= wr_val(ectl_q, WMASK_ECTL);
      end
      if (wr_eentry) begin
        eentry_q <= wr_val(eentry_q, WMASK_EENTRY);
      end
      if (wr_tid) begin
        tid_q <= wr_val(tid_q, WMASK_FULL);
      end
      for (int i = 0; i < NUM_SAVE; i++) begin
        if (csr_we_i && (csr_w_addr_i == CSR_SAVE_ADDR[i])) begin
          save_q[i] <= wr_val(save_q[i], WMASK_FULL);
        end
      end
    end
  end

  // ti lives in the timer
  always_comb begin
    estat_word           = estat_q;
    estat_word[ESTAT_TI] = timer_int_i;
  end

  assign int_o = crmd_q[CRMD_IE] &&
                 |(estat_word[ESTAT_IS_HI:0] & ectl_q[ESTAT_IS_HI:0]);

  always_comb begin
    rd_data = '0;
    if (rdcnt_i == RDCNT_NONE) begin
      case (csr_r_addr_i)
        CSR_CRMD:   rd_data = crmd_q;
        CSR_PRMD:   rd_data = prmd_q;
        CSR_ECTL:   rd_data = ectl_q;
        CSR_ESTAT:  rd_data = estat_word;
        CSR_ERA:    rd_data = era_q;
        CSR_BADV:   rd_data = badv_q;
        CSR_EENTRY: rd_data = eentry_q;
        CSR_TID:    rd_data = tid_q;
        CSR_TCFG:   rd_data = tcfg_i;
        CSR_TVAL:   rd_data = tval_i;
        // write-only clear strobe
        CSR_TICLR:  rd_data = '0;
        default: begin
          for (int i = 0; i < NUM_SAVE; i++) begin
            if (csr_r_addr_i == CSR_SAVE_ADDR[i]) begin
              rd_data = save_q[i];
            end
          end
        end
      endcase
    end else begin
      case (rdcnt_i)
        RDCNT_ID:   rd_data = tid_q;
        RDCNT_LOW:  rd_data = stable_cnt_i[31:0];
        RDCNT_HIGH: rd_data = stable_cnt_i[63:32];
        default:    rd_data = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    csr_r_data_o <= rd_data;
  end

  assign crmd_o   = crmd_q;
  assign era_o    = era_q;
  assign eentry_o = eentry_q;

  // exception entry and return come from different pipeline slots
  a_excp_ertn_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(excp_valid_i && ertn_i));

  // interrupts are masked right after exception entry
  a_int_masked: assert property (@(posedge clk) disable iff (!rst_n)
    (excp_valid_i && !wr_crmd) |=> !int_o);

endmodule

/* la_csr_unit.sv */
`timescale 1ns/1ps

module la_csr_unit import csr_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       csr_we_i,
  input  csr_addr_t  csr_w_addr_i,
  input  word_t      csr_w_mask_i,
  input  word_t      csr_w_data_i,
  input  csr_addr_t  csr_r_addr_i,
  input  rdcnt_t     rdcnt_i,
  input  excp_vec_t  excp_i,
  input  word_t      pc_i,
  input  word_t      vaddr_i,
  input  logic       ertn_i,
  input  logic [7:0] int_i,
  output word_t      crmd_o,
  output word_t      era_o,
  output word_t      eentry_o,
  output logic       int_o,
  output word_t      csr_r_data_o
);

  logic        excp_valid;
  ecode_t      ecode;
  esubcode_t   esubcode;
  logic        badv_we;
  word_t       badv_val;
  word_t       tcfg;
  word_t       tval;
  logic        timer_int;
  logic [63:0] stable_cnt;

  csr_excp_unit i_excp (
    .excp_i       (excp_i),
    .pc_i         (pc_i),
    .vaddr_i      (vaddr_i),
    .excp_valid_o (excp_valid),
    .ecode_o      (ecode),
    .esubcode_o   (esubcode),
    .badv_we_o    (badv_we),
    .badv_val_o   (badv_val)
  );

  csr_timer i_timer (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_we_i     (csr_we_i),
    .csr_w_addr_i (csr_w_addr_i),
    .csr_w_mask_i (csr_w_mask_i),
    .csr_w_data_i (csr_w_data_i),
    .tcfg_o       (tcfg),
    .tval_o       (tval),
    .timer_int_o  (timer_int),
    .stable_cnt_o (stable_cnt)
  );

  csr_regfile i_regfile (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_we_i     (csr_we_i),
    .csr_w_addr_i (csr_w_addr_i),
    .csr_w_mask_i (csr_w_mask_i),
    .csr_w_data_i (csr_w_data_i),
    .csr_r_addr_i (csr_r_addr_i),
    .rdcnt_i      (rdcnt_i),
    .excp_valid_i (excp_valid),
    .ecode_i      (ecode),
    .esubcode_i   (esubcode),
    .badv_we_i    (badv_we),
    .badv_val_i   (badv_val),
    .pc_i         (pc_i),
    .ertn_i       (ertn_i),
    .int_i        (int_i),
    .tcfg_i       (tcfg),
    .tval_i       (tval),
    .timer_int_i  (timer_int),
    .stable_cnt_i (stable_cnt),
    .crmd_o       (crmd_o),
    .era_o        (era_o),
    .eentry_o     (eentry_o),
    .int_o        (int_o),
    .csr_r_data_o (csr_r_data_o)
  );

endmodule

/* tb_la_csr_unit.sv */
`timescale 1ns/1ps

module tb_la_csr_unit import csr_pkg::*; ();

  // all tests together take a few hundred cycles
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int NUM_RW = 13;
  localparam csr_addr_t RW_ADDRS [NUM_RW] = '{CSR_CRMD, CSR_PRMD, CSR_ECTL, CSR_ESTAT,
    CSR_ERA, CSR_BADV, CSR_EENTRY, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID,
    CSR_TCFG};

  logic       clk;
  logic       rst_n;
  logic       csr_we_i;
  csr_addr_t  csr_w_addr_i;
  word_t      csr_w_mask_i;
  word_t      csr_w_data_i;
  csr_addr_t  csr_r_addr_i;
  rdcnt_t     rdcnt_i;
  excp_vec_t  excp_i;
  word_t      pc_i;
  word_t      vaddr_i;
  logic       ertn_i;
  logic [7:0] int_i;
  word_t      crmd_o;
  word_t      era_o;
  word_t      eentry_o;
  logic       int_o;
  word_t      csr_r_data_o;

  word_t model [csr_addr_t];
  word_t rand_state;
  int    error_count;
  int    check_count;
  int    cycle_count = 0;

  la_csr_unit i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_we_i     (csr_we_i),
    .csr_w_addr_i (csr_w_addr_i),
    .csr_w_mask_i (csr_w_mask_i),
    .csr_w_data_i (csr_w_data_i),
    .csr_r_addr_i (csr_r_addr_i),
    .rdcnt_i      (rdcnt_i),
    .excp_i       (excp_i),
    .pc_i         (pc_i),
    .vaddr_i      (vaddr_i),
    .ertn_i       (ertn_i),
    .int_i        (int_i),
    .crmd_o       (crmd_o),
    .era_o        (era_o),
    .eentry_o     (eentry_o),
    .int_o        (int_o),
    .csr_r_data_o (csr_r_data_o)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  function automatic word_t next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  task automatic check(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic write_csr(input csr_addr_t addr, input word_t mask, input word_t data);
    csr_we_i     = 1'b1;
    csr_w_addr_i = addr;
    csr_w_mask_i = mask;
    csr_w_data_i = data;
    tick();
    csr_we_i = 1'b0;
  endtask

  task automatic read_csr(input csr_addr_t addr, output word_t data);
    csr_r_addr_i = addr;
    rdcnt_i      = RDCNT_NONE;
    tick();
    data = csr_r_data_o;
  endtask

  task automatic read_cnt(input rdcnt_t sel, output word_t data);
    rdcnt_i = sel;
    tick();
    data    = csr_r_data_o;
    rdcnt_i = RDCNT_NONE;
  endtask

  task automatic check_csr(input csr_addr_t addr, input word_t exp);
    word_t data;
    read_csr(addr, data);
    check($sformatf("csr_r_data_o @0x%03h", addr), data, exp);
  endtask

  function automatic word_t writable_mask(csr_addr_t addr);
    case (addr)
      CSR_CRMD:   return 32'h0000_01ff;
      CSR_PRMD:   return 32'h0000_0007;
      CSR_ECTL:   return 32'h0000_1bff;
      CSR_ESTAT:  return 32'h0000_0003;
      CSR_EENTRY: return 32'hffff_ffc0;
      default:    return 32'hffff_ffff;
    endcase
  endfunction

  // lowest raised index wins
  function automatic int first_cause(excp_vec_t vec);
    for (int i = 0; i < 8; i++) begin
      if (vec[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic word_t cause_ecode(int cause);
    case (cause)
      EXC_ADEF: return 32'h8;
      EXC_ADEM: return 32'h8;
      EXC_ALE:  return 32'h9;
      EXC_SYS:  return 32'hb;
      EXC_BRK:  return 32'hc;
      EXC_INE:  return 32'hd;
      EXC_IPE:  return 32'he;
      default:  return 32'h0;
    endcase
  endfunction

  task automatic park_timer();
    write_csr(CSR_TCFG, 32'hffff_ffff, 32'h0);
    model[CSR_TCFG] = 32'h0;
    write_csr(CSR_TICLR, 32'h1, 32'h1);
  endtask

  task automatic wait_timer_int(input int limit);
    word_t data;
    int    waited;
    waited = 0;
    data   = 32'h0;
    while (!data[ESTAT_TI] && waited < limit) begin
      read_csr(CSR_ESTAT, data);
      waited++;
    end
    check_count++;
    if (!data[ESTAT_TI]) begin
      error_count++;
      $display("timer interrupt did not set within %0d cycles", limit);
    end
  endtask

  task automatic test_reset();
    for (int i = 0; i < NUM_RW; i++) begin
      model[RW_ADDRS[i]] = 32'h0;
    end
    model[CSR_CRMD] = 32'h0000_0008;
    check("int_o", word_t'(int_o), 32'h0);
    for (int i = 0; i < NUM_RW; i++) begin
      check_csr(RW_ADDRS[i], model[RW_ADDRS[i]]);
    end
    check_csr(CSR_TVAL, 32'h0);
    check_csr(CSR_TICLR, 32'h0);
  endtask

  task automatic test_masked_writes();
    word_t     data;
    word_t     mask;
    word_t     eff;
    csr_addr_t addr;
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < NUM_RW; i++) begin
        addr = RW_ADDRS[i];
        data = next_rand();
        mask = next_rand();
        write_csr(addr, mask, data);
        eff = mask & writable_mask(addr);
        model[addr] = (model[addr] & ~eff) | (data & eff);
        if (addr == CSR_TCFG) begin
          // count starts at initval times four
          check_csr(CSR_TVAL, model[addr] & 32'hffff_fffc);
        end
        check_csr(addr, model[addr]);
        if (addr == CSR_EENTRY) begin
          check("eentry_o", eentry_o, model[addr]);
        end
      end
      park_timer();
    end
    check_csr(14'h099, 32'h0);
    check_csr(CSR_TICLR, 32'h0);
  endtask

  task automatic raise_exception(input excp_vec_t vec);
    word_t pc;
    word_t va;
    word_t sub;
    int    cause;
    pc    = next_rand();
    va    = next_rand();
    cause = first_cause(vec);
    sub   = (cause == EXC_ADEM) ? 32'h1 : 32'h0;
    write_csr(CSR_CRMD, 32'h7, 32'h7);
    model[CSR_CRMD] = model[CSR_CRMD] | 32'h7;
    excp_i  = vec;
    pc_i    = pc;
    vaddr_i = va;
    tick();
    excp_i = '0;
    check("era_o", era_o, pc);
    model[CSR_PRMD]  = model[CSR_PRMD] | 32'h7;
    model[CSR_CRMD]  = model[CSR_CRMD] & ~32'h7;
    model[CSR_ESTAT] = (model[CSR_ESTAT] & 32'h8000_ffff) | (cause_ecode(cause) << 16) |
                       (sub << 22);
    model[CSR_ERA]   = pc;
    if (cause == EXC_ADEF) begin
      model[CSR_BADV] = pc;
    end else if (cause == EXC_ADEM || cause == EXC_ALE) begin
      model[CSR_BADV] = va;
    end
    check_csr(CSR_PRMD, model[CSR_PRMD]);
    check_csr(CSR_CRMD, model[CSR_CRMD]);
    check_csr(CSR_ESTAT, model[CSR_ESTAT]);
    check_csr(CSR_ERA, model[CSR_ERA]);
    check_csr(CSR_BADV, model[CSR_BADV]);
    ertn_i = 1'b1;
    tick();
    ertn_i = 1'b0;
    model[CSR_CRMD] = model[CSR_CRMD] | 32'h7;
    check("crmd_o", crmd_o, model[CSR_CRMD]);
    check_csr(CSR_CRMD, model[CSR_CRMD]);
  endtask

  task automatic test_exceptions();
    for (int i = 0; i < 8; i++) begin
      raise_exception(excp_vec_t'(1 << i));
    end
    raise_exception(excp_vec_t'((1 << EXC_ALE) | (1 << EXC_SYS)));
  endtask

  task automatic test_interrupts();
    write_csr(CSR_ECTL, 32'hffff_ffff, 32'h1);
    model[CSR_ECTL] = 32'h1;
    write_csr(CSR_ESTAT, 32'h3, 32'h1);
    model[CSR_ESTAT] = (model[CSR_ESTAT] & ~32'h3) | 32'h1;
    write_csr(CSR_CRMD, 32'h4, 32'h4);
    model[CSR_CRMD] = model[CSR_CRMD] | 32'h4;
    check("int_o", word_t'(int_o), 32'h1);
    write_csr(CSR_CRMD, 32'h4, 32'h0);
    model[CSR_CRMD] = model[CSR_CRMD] & ~32'h4;
    check("int_o", word_t'(int_o), 32'h0);
    write_csr(CSR_ESTAT, 32'h3, 32'h0);
    model[CSR_ESTAT] = model[CSR_ESTAT] & ~32'h3;
    int_i = 8'h20;
    tick();
    check_csr(CSR_ESTAT, model[CSR_ESTAT] | (32'h20 << 2));
    int_i = 8'h00;
    tick();
  endtask

  task automatic test_timer();
    word_t data;
    // one-shot, initval 5
    write_csr(CSR_TCFG, 32'hffff_ffff, 32'h0000_0015);
    wait_timer_int(5 * 4 + 4);
    check_csr(CSR_TVAL, 32'hffff_ffff);
    repeat (5) tick();
    read_csr(CSR_ESTAT, data);
    check("estat ti (held)", word_t'(data[ESTAT_TI]), 32'h1);
    write_csr(CSR_TICLR, 32'h1, 32'h1);
    read_csr(CSR_ESTAT, data);
    check("estat ti (cleared)", word_t'(data[ESTAT_TI]), 32'h0);
    // periodic, initval 3
    write_csr(CSR_TCFG, 32'hffff_ffff, 32'h0000_000f);
    wait_timer_int(3 * 4 + 4);
    write_csr(CSR_TICLR, 32'h1, 32'h1);
    read_csr(CSR_ESTAT, data);
    check("estat ti (periodic clear)", word_t'(data[ESTAT_TI]), 32'h0);
    wait_timer_int(3 * 4 + 4);
    park_timer();
  endtask

  task automatic test_stable_counter();
    word_t first;
    word_t second;
    word_t data;
    read_cnt(RDCNT_LOW, first);
    repeat (19) tick();
    read_cnt(RDCNT_LOW, second);
    check("csr_r_data_o rdcnt low delta", second - first, 32'd20);
    read_cnt(RDCNT_ID, data);
    check("csr_r_data_o rdcnt id", data, model[CSR_TID]);
    read_cnt(RDCNT_HIGH, data);
    check("csr_r_data_o rdcnt high", data, 32'h0);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    csr_we_i     = 1'b0;
    csr_w_addr_i = '0;
    csr_w_mask_i = '0;
    csr_w_data_i = '0;
    csr_r_addr_i = '0;
    rdcnt_i      = RDCNT_NONE;
    excp_i       = '0;
    pc_i         = '0;
    vaddr_i      = '0;
    ertn_i       = 1'b0;
    int_i        = '0;
    rand_state   = 32'h1f8f_c003;
    error_count  = 0;
    check_count  = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_masked_writes();
    test_exceptions();
    test_interrupts();
    test_timer();
    test_stable_counter();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
csr_pkg.sv
csr_excp_unit.sv
csr_timer.sv
csr_regfile.sv
la_csr_unit.sv
tb_la_csr_unit.sv

/* run.sh */
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_la_csr_unit -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished without failures"
